/* cache_sim_top.f */
+incdir+src
src/cache_sim_pkg.sv
src/tag_lookup_if.sv
src/lookup_fsm.sv
src/tag_set_array.sv
src/hit_miss_counters.sv
src/cache_sim_top.sv
dv/cache_sim_tb.sv

/* dv/cache_sim_tb.sv */
`default_nettype none

`include "cache_sim_consts.svh"

module cache_sim_tb;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int L1_TAG_LSB = `CACHE_OFFSET_W + `CACHE_L1_SET_W;
  localparam int L2_TAG_LSB = `CACHE_OFFSET_W + `CACHE_L2_SET_W;

  // One set of the model with way 0 at the front of the queue
  typedef int unsigned tag_queue_t[$];

  // Outcome of one accepted request and the counters as they stand after it
  typedef struct {
    bit          l1_hit;
    bit          l2_hit;
    int unsigned l1_hits;
    int unsigned l1_misses;
    int unsigned l2_hits;
    int unsigned l2_misses;
  } expect_t;

  logic                      clk;
  logic                      reset;
  logic                      req_valid;
  logic                      req_ready;
  logic [`CACHE_ADDR_W-1:0]  req_addr;
  logic                      req_replace_lru;
  logic                      resp_valid;
  logic                      resp_l1_hit;
  logic                      resp_l2_hit;
  logic [`CACHE_COUNT_W-1:0] l1_hits;
  logic [`CACHE_COUNT_W-1:0] l1_misses;
  logic [`CACHE_COUNT_W-1:0] l2_hits;
  logic [`CACHE_COUNT_W-1:0] l2_misses;

  // Reference state for both levels and the expected statistics
  tag_queue_t  l1_model [`CACHE_L1_SETS];
  tag_queue_t  l2_model [`CACHE_L2_SETS];
  int unsigned ref_l1_hits;
  int unsigned ref_l1_misses;
  int unsigned ref_l2_hits;
  int unsigned ref_l2_misses;

  // Requests accepted but not yet answered
  expect_t expect_q[$];

  string test_name;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;
  int    accept_count;
  int    resp_count;

  cache_sim_top i_dut (
    .clk             (clk),
    .reset           (reset),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .req_addr        (req_addr),
    .req_replace_lru (req_replace_lru),
    .resp_valid      (resp_valid),
    .resp_l1_hit     (resp_l1_hit),
    .resp_l2_hit     (resp_l2_hit),
    .l1_hits         (l1_hits),
    .l1_misses       (l1_misses),
    .l2_hits         (l2_hits),
    .l2_misses       (l2_misses)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Looks a tag up in one set and applies the miss insert or the LRU move
  function automatic bit touch_set(inout tag_queue_t ways_q, input int unsigned tag,
                                   input bit lru, input int num_ways);
    int hit_idx = -1;
    foreach (ways_q[i]) begin
      if (hit_idx < 0 && ways_q[i] == tag) hit_idx = i;
    end
    if (hit_idx >= 0) begin
      // FIFO leaves the set alone on a hit
      if (lru) begin
        ways_q.delete(hit_idx);
        ways_q.push_front(tag);
      end
      return 1'b1;
    end
    ways_q.push_front(tag);
    if (ways_q.size() > num_ways) void'(ways_q.pop_back());
    return 1'b0;
  endfunction

  // In a non-inclusive access L2 is only looked at and filled after an L1 miss
  function automatic expect_t model_access(input logic [`CACHE_ADDR_W-1:0] addr, input bit lru);
    expect_t     e;
    int unsigned l1_set;
    int unsigned l2_set;
    l1_set   = addr[`CACHE_OFFSET_W +: `CACHE_L1_SET_W];
    l2_set   = addr[`CACHE_OFFSET_W +: `CACHE_L2_SET_W];
    e.l1_hit = touch_set(l1_model[l1_set], addr >> L1_TAG_LSB, lru, `CACHE_L1_WAYS);
    e.l2_hit = 1'b0;
    if (e.l1_hit) begin
      ref_l1_hits++;
    end else begin
      ref_l1_misses++;
      e.l2_hit = touch_set(l2_model[l2_set], addr >> L2_TAG_LSB, lru, `CACHE_L2_WAYS);
      if (e.l2_hit) ref_l2_hits++;
      else ref_l2_misses++;
    end
    e.l1_hits   = ref_l1_hits;
    e.l1_misses = ref_l1_misses;
    e.l2_hits   = ref_l2_hits;
    e.l2_misses = ref_l2_misses;
    return e;
  endfunction

  // The L1 set is the same for every k while the L2 set follows the low bits of k
  function automatic logic [`CACHE_ADDR_W-1:0] colliding_addr(input int k, input int l1_set);
    return (k << 16) | ((k % 4) << 10) | (l1_set << 6);
  endfunction

  //////////////////////////////
  // Checking and reporting
  //////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("FAIL %s %s: expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic note_problem(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    $display("Test failures found");
    $finish;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) tests_failed++;
    if (test_errors == 0) $display("test %s: ok", test_name);
    else $display("test %s: %0d errors", test_name, test_errors);
  endtask

  // Every response pulse is matched against the oldest outstanding request
  always @(negedge clk) begin : compare_resp
    expect_t e;
    if (!reset && resp_valid) begin
      resp_count++;
      assert (expect_q.size() != 0) else note_problem("response with no request outstanding");
      if (expect_q.size() != 0) begin
        e = expect_q.pop_front();
        check_value("resp_l1_hit", e.l1_hit, resp_l1_hit);
        check_value("resp_l2_hit", e.l2_hit, resp_l2_hit);
        check_value("l1_hits", e.l1_hits, l1_hits);
        check_value("l1_misses", e.l1_misses, l1_misses);
        check_value("l2_hits", e.l2_hits, l2_hits);
        check_value("l2_misses", e.l2_misses, l2_misses);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // One complete request from raising req_valid to the return of req_ready
  task automatic access(input logic [`CACHE_ADDR_W-1:0] addr, input bit lru,
                        output expect_t seen);
    int      cycles;
    bit      ready_seen;
    bit      resp_seen;
    expect_t want;
    @(posedge clk);
    req_valid       <= 1'b1;
    req_addr        <= addr;
    req_replace_lru <= lru;
    // Hold the request until an edge finds req_ready high
    cycles     = 0;
    ready_seen = 1'b0;
    while (!ready_seen) begin
      if (cycles == TIMEOUT_CYCLES) abort_run("timed out waiting for req_ready");
      @(negedge clk);
      ready_seen = req_ready;
      @(posedge clk);
      cycles++;
    end
    req_valid <= 1'b0;
    accept_count++;
    want = model_access(addr, lru);
    expect_q.push_back(want);
    // Ready stays low from SEARCH through the response cycle
    cycles    = 0;
    resp_seen = 1'b0;
    while (!resp_seen) begin
      if (cycles == TIMEOUT_CYCLES) abort_run("timed out waiting for resp_valid");
      @(negedge clk);
      assert (!req_ready) else note_problem("req_ready high while a request was in flight");
      resp_seen = resp_valid;
      cycles++;
    end
    // The DUT's answer as it stands in the response cycle
    seen.l1_hit    = resp_l1_hit;
    seen.l2_hit    = resp_l2_hit;
    seen.l1_hits   = l1_hits;
    seen.l1_misses = l1_misses;
    seen.l2_hits   = l2_hits;
    seen.l2_misses = l2_misses;
    @(negedge clk);
    assert (req_ready) else note_problem("req_ready did not return after the response");
    assert (!resp_valid) else note_problem("resp_valid lasted more than one cycle");
  endtask

  initial begin
    expect_t e;
    void'($urandom(54245));
    reset           = 1'b1;
    req_valid       = 1'b0;
    req_addr        = '0;
    req_replace_lru = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    start_test("reset_state");
    @(negedge clk);
    check_value("req_ready", 1, req_ready);
    check_value("resp_valid", 0, resp_valid);
    check_value("l1_hits", 0, l1_hits);
    check_value("l1_misses", 0, l1_misses);
    check_value("l2_hits", 0, l2_hits);
    check_value("l2_misses", 0, l2_misses);
    access(32'h0000_1040, 1'b0, e);
    check_value("first l1_hit", 0, e.l1_hit);
    check_value("first l2_hit", 0, e.l2_hit);
    finish_test();

    // Another offset in the same block and then a fresh block under LRU
    start_test("repeat_hit");
    access(32'h0000_1048, 1'b0, e);
    check_value("fifo repeat l1_hit", 1, e.l1_hit);
    check_value("fifo repeat l2_hits", 0, e.l2_hits);
    check_value("fifo repeat l2_misses", 1, e.l2_misses);
    access(32'h0002_2080, 1'b1, e);
    access(32'h0002_20a4, 1'b1, e);
    check_value("lru repeat l1_hit", 1, e.l1_hit);
    check_value("lru repeat l2_hits", 0, e.l2_hits);
    check_value("lru repeat l2_misses", 2, e.l2_misses);
    finish_test();

    start_test("fifo_eviction");
    for (int k = 1; k <= 4; k++) access(colliding_addr(k, 3), 1'b0, e);
    access(colliding_addr(1, 3), 1'b0, e);
    access(colliding_addr(5, 3), 1'b0, e);
    access(colliding_addr(1, 3), 1'b0, e);
    check_value("evicted l1_hit", 0, e.l1_hit);
    check_value("evicted l2_hit", 1, e.l2_hit);
    access(colliding_addr(1, 3), 1'b0, e);
    check_value("refilled l1_hit", 1, e.l1_hit);
    finish_test();

    // A is touched again before E arrives, so B becomes the oldest
    start_test("lru_ordering");
    for (int k = 1; k <= 4; k++) access(colliding_addr(k, 5), 1'b1, e);
    access(colliding_addr(1, 5), 1'b1, e);
    access(colliding_addr(5, 5), 1'b1, e);
    access(colliding_addr(1, 5), 1'b1, e);
    check_value("A l1_hit", 1, e.l1_hit);
    access(colliding_addr(2, 5), 1'b1, e);
    check_value("B l1_hit", 0, e.l1_hit);
    check_value("B l2_hit", 1, e.l2_hit);
    finish_test();

    // Ten tags over two L2 sets that share L1 set 7, so both levels thrash
    start_test("random_stream");
    for (int n = 0; n < 200; n++) begin
      access(($urandom_range(0, 9) << 12) | (($urandom_range(0, 1) ? 6'h17 : 6'h07) << 6)
             | $urandom_range(0, 63), $urandom_range(0, 1), e);
    end
    finish_test();

    start_test("ready_behavior");
    for (int n = 0; n < 3; n++) access(colliding_addr(n, 9), n[0], e);
    check_value("responses per accepted request", accept_count, resp_count);
    finish_test();

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/cache_sim_top.sv */
`default_nettype none

`include "cache_sim_consts.svh"

module cache_sim_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  logic [`CACHE_ADDR_W-1:0]  req_addr,
  input  logic                      req_replace_lru,
  output logic                      resp_valid,
  output logic                      resp_l1_hit,
  output logic                      resp_l2_hit,
  output logic [`CACHE_COUNT_W-1:0] l1_hits,
  output logic [`CACHE_COUNT_W-1:0] l1_misses,
  output logic [`CACHE_COUNT_W-1:0] l2_hits,
  output logic [`CACHE_COUNT_W-1:0] l2_misses
);

  import cache_sim_pkg::*;

  cache_addr_t req_word;
  logic count_en;

  assign req_word.raw = req_addr;

  // One lookup channel per level
  tag_lookup_if #(.TAG_W(`CACHE_L1_TAG_W), .SET_W(`CACHE_L1_SET_W)) l1_lookup ();
  tag_lookup_if #(.TAG_W(`CACHE_L2_TAG_W), .SET_W(`CACHE_L2_SET_W)) l2_lookup ();

  lookup_fsm i_lookup_fsm (
    .clk             (clk),
    .reset           (reset),
    .req_valid       (req_valid),
    .req_addr        (req_word),
    .req_replace_lru (req_replace_lru),
    .req_ready       (req_ready),
    .resp_valid      (resp_valid),
    .resp_l1_hit     (resp_l1_hit),
    .resp_l2_hit     (resp_l2_hit),
    .count_en        (count_en),
    .l1_port         (l1_lookup.fsm_side),
    .l2_port         (l2_lookup.fsm_side)
  );

  tag_set_array #(
    .NUM_SETS (`CACHE_L1_SETS),
    .NUM_WAYS (`CACHE_L1_WAYS),
    .TAG_W    (`CACHE_L1_TAG_W),
    .SET_W    (`CACHE_L1_SET_W)
  ) i_l1_array (
    .clk    (clk),
    .reset  (reset),
    .lookup (l1_lookup.array_side)
  );

  tag_set_array #(
    .NUM_SETS (`CACHE_L2_SETS),
    .NUM_WAYS (`CACHE_L2_WAYS),
    .TAG_W    (`CACHE_L2_TAG_W),
    .SET_W    (`CACHE_L2_SET_W)
  ) i_l2_array (
    .clk    (clk),
    .reset  (reset),
    .lookup (l2_lookup.array_side)
  );

  // Counters take the registered response flags with the update strobe
  hit_miss_counters #(.COUNT_W(`CACHE_COUNT_W)) i_counters (
    .clk       (clk),
    .reset     (reset),
    .count_en  (count_en),
    .l1_hit    (resp_l1_hit),
    .l2_hit    (resp_l2_hit),
    .l1_hits   (l1_hits),
    .l1_misses (l1_misses),
    .l2_hits   (l2_hits),
    .l2_misses (l2_misses)
  );

endmodule

`default_nettype wire

/* src/hit_miss_counters.sv */
`default_nettype none

`include "cache_sim_consts.svh"

module hit_miss_counters #(
  parameter int COUNT_W = `CACHE_COUNT_W
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               count_en,
  input  logic               l1_hit,
  input  logic               l2_hit,
  output logic [COUNT_W-1:0] l1_hits,
  output logic [COUNT_W-1:0] l1_misses,
  output logic [COUNT_W-1:0] l2_hits,
  output logic [COUNT_W-1:0] l2_misses
);

  // Next count, held at all ones once it gets there
  function automatic logic [COUNT_W-1:0] sat_inc(input logic [COUNT_W-1:0] value);
    return (&value) ? value : value + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      l1_hits   <= '0;
      l1_misses <= '0;
      l2_hits   <= '0;
      l2_misses <= '0;
    end else if (count_en) begin
      // Every access is counted once at L1
      if (l1_hit) begin
        l1_hits <= sat_inc(l1_hits);
      end else begin
        l1_misses <= sat_inc(l1_misses);
        // Only accesses that missed L1 reach L2
        if (l2_hit) begin
          l2_hits <= sat_inc(l2_hits);
        end else begin
          l2_misses <= sat_inc(l2_misses);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/tag_set_array.sv */
`default_nettype none

`include "cache_sim_consts.svh"

module tag_set_array #(
  parameter int NUM_SETS = `CACHE_L1_SETS,
  parameter int NUM_WAYS = `CACHE_L1_WAYS,
  parameter int TAG_W    = `CACHE_L1_TAG_W,
  parameter int SET_W    = `CACHE_L1_SET_W
) (
  input  logic             clk,
  input  logic             reset,
  tag_lookup_if.array_side lookup
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Way 0 of each set is the front, the last way is the next to be dropped
  logic [NUM_WAYS-1:0][TAG_W-1:0] tags [NUM_SETS];
  logic [NUM_WAYS-1:0]            valid [NUM_SETS];

  logic [SET_W-1:0] set_sel;

  // Contents of the addressed set
  logic [NUM_WAYS-1:0][TAG_W-1:0] set_tags;
  logic [NUM_WAYS-1:0]            set_valid;

  // Per-way compare result and the first matching way
  logic [NUM_WAYS-1:0] way_match;
  logic [WAY_W-1:0]    hit_way;

  // Replacement result for the addressed set
  logic [NUM_WAYS-1:0][TAG_W-1:0] set_tags_next;
  logic [NUM_WAYS-1:0]            set_valid_next;
  logic                           set_write;

  assign set_sel   = lookup.set_index;
  assign set_tags  = tags[set_sel];
  assign set_valid = valid[set_sel];

  //////////////////////////////
  // Hit detection
  //////////////////////////////

  // Empty ways never match, so tag zero is a usable tag
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_match[w] = set_valid[w] && (set_tags[w] == lookup.tag);
    end
    // Scan from the back so the lowest matching way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_match[w]) hit_way = WAY_W'(w);
    end
  end

  assign lookup.hit = |way_match;

  //////////////////////////////
  // Replacement
  //////////////////////////////

  // A miss shifts the whole set back and inserts at the front.
  // An LRU hit shifts only the ways ahead of the hit way and moves it forward.
  always_comb begin
    set_tags_next  = set_tags;
    set_valid_next = set_valid;
    for (int w = 1; w < NUM_WAYS; w++) begin
      if (!lookup.hit || w <= int'(hit_way)) begin
        set_tags_next[w]  = set_tags[w-1];
        set_valid_next[w] = set_valid[w-1];
      end
    end
    set_tags_next[0]  = lookup.tag;
    set_valid_next[0] = 1'b1;
  end

  // A FIFO hit leaves the set exactly as it was
  assign set_write = lookup.update_en && (!lookup.hit || lookup.replace_lru);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid[s] <= '0;
      end
    end else if (set_write) begin
      valid[set_sel] <= set_valid_next;
    end
  end

  // Tags carry no meaning until their valid bit is set
  always_ff @(posedge clk) begin
    if (set_write) begin
      tags[set_sel] <= set_tags_next;
    end
  end

endmodule

`default_nettype wire

/* src/lookup_fsm.sv */
`default_nettype none

module lookup_fsm (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_valid,
  input  cache_sim_pkg::cache_addr_t req_addr,
  input  logic                      req_replace_lru,
  output logic                      req_ready,
  output logic                      resp_valid,
  output logic                      resp_l1_hit,
  output logic                      resp_l2_hit,
  output logic                      count_en,
  tag_lookup_if.fsm_side            l1_port,
  tag_lookup_if.fsm_side            l2_port
);

  import cache_sim_pkg::*;

  lookup_state_t state;
  lookup_state_t state_next;

  // Captured request
  cache_addr_t addr_q;
  logic lru_q;

  // Hit flags sampled at the end of SEARCH
  logic l1_hit_q;
  logic l2_hit_q;

  //////////////////////////////
  // State sequencing
  //////////////////////////////

  // Each accepted request walks SEARCH, UPDATE and RESPOND exactly once
  always_comb begin
    state_next = state;
    unique case (state)
      IDLE:    if (req_valid) state_next = SEARCH;
      SEARCH:  state_next = UPDATE;
      UPDATE:  state_next = RESPOND;
      RESPOND: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      l1_hit_q <= 1'b0;
      l2_hit_q <= 1'b0;
    end else begin
      state <= state_next;
      // Both arrays compare in SEARCH; an L1 hit masks the L2 result
      if (state == SEARCH) begin
        l1_hit_q <= l1_port.hit;
        l2_hit_q <= l2_port.hit & ~l1_port.hit;
      end
    end
  end

  // Address and policy are only meaningful while a request is in flight
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      addr_q <= req_addr;
      lru_q  <= req_replace_lru;
    end
  end

  //////////////////////////////
  // Array ports
  //////////////////////////////

  // Each level sees the captured address through its own split
  assign l1_port.tag         = addr_q.l1.tag;
  assign l1_port.set_index   = addr_q.l1.set_index;
  assign l1_port.replace_lru = lru_q;
  assign l2_port.tag         = addr_q.l2.tag;
  assign l2_port.set_index   = addr_q.l2.set_index;
  assign l2_port.replace_lru = lru_q;

  // L1 always updates; L2 is only touched when the access reached it
  assign l1_port.update_en = (state == UPDATE);
  assign l2_port.update_en = (state == UPDATE) && !l1_hit_q;

  //////////////////////////////
  // Requester side
  //////////////////////////////

  assign req_ready   = (state == IDLE);
  assign resp_valid  = (state == RESPOND);
  assign resp_l1_hit = l1_hit_q;
  assign resp_l2_hit = l2_hit_q;

  // Counters move on the same edge as the arrays
  assign count_en = (state == UPDATE);

endmodule

`default_nettype wire

/* src/tag_lookup_if.sv */
`default_nettype none

// Connects the lookup FSM to one level's tag array
interface tag_lookup_if #(
  parameter int TAG_W = 22,
  parameter int SET_W = 4
);

  // Tag and set of the address being looked up
  logic [TAG_W-1:0] tag;
  logic [SET_W-1:0] set_index;

  // Replacement policy of the request, 1 selects LRU and 0 selects FIFO
  logic replace_lru;

  // Array commits its set update on the edge ending a cycle with this high
  logic update_en;

  // Combinational match of tag against the valid ways of set_index
  logic hit;

  modport fsm_side (
    output tag, set_index, replace_lru, update_en,
    input  hit
  );

  modport array_side (
    input  tag, set_index, replace_lru, update_en,
    output hit
  );

endinterface

`default_nettype wire

/* src/cache_sim_pkg.sv */
`default_nettype none

`include "cache_sim_consts.svh"

package cache_sim_pkg;

  //////////////////////////////
  // Address views
  //////////////////////////////

  // Address split the way L1 indexes it
  typedef struct packed {
    logic [`CACHE_L1_TAG_W-1:0] tag;
    logic [`CACHE_L1_SET_W-1:0] set_index;
    logic [`CACHE_OFFSET_W-1:0] offset;
  } l1_view_t;

  // Same address split for L2, with fewer tag bits and more set bits
  typedef struct packed {
    logic [`CACHE_L2_TAG_W-1:0] tag;
    logic [`CACHE_L2_SET_W-1:0] set_index;
    logic [`CACHE_OFFSET_W-1:0] offset;
  } l2_view_t;

  // One request word, read as raw bits or through either level's view
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] raw;
    l1_view_t l1;
    l2_view_t l2;
  } cache_addr_t;

  // Lookup sequencing, one request in flight at a time
  typedef enum logic [1:0] {IDLE, SEARCH, UPDATE, RESPOND} lookup_state_t;

endpackage

`default_nettype wire

/* src/cache_sim_consts.svh */
`ifndef CACHE_SIM_CONSTS_SVH
`define CACHE_SIM_CONSTS_SVH

// Byte address presented with each request
`define CACHE_ADDR_W 32

// One block is 64 bytes, so the low 6 address bits are the offset
`define CACHE_BLOCK_BYTES 64
`define CACHE_OFFSET_W 6

// L1 geometry is 16 sets of 4 ways
`define CACHE_L1_SETS 16
`define CACHE_L1_WAYS 4
`define CACHE_L1_SET_W 4
`define CACHE_L1_TAG_W 22

// L2 geometry is 64 sets of 8 ways
`define CACHE_L2_SETS 64
`define CACHE_L2_WAYS 8
`define CACHE_L2_SET_W 6
`define CACHE_L2_TAG_W 20

// Width of each statistics counter
`define CACHE_COUNT_W 18

`endif
